// ==== tb.f ====
common/mesh_pkg.sv
design/router/router_in_buf.sv
design/router/router_out_arb.sv
design/router/mesh_router.sv
design/nic/mesh_nic.sv
design/mesh_top.sv
tb/mesh_tb.sv

// ==== Bender.yml ====
package:
  name: mesh_noc

sources:
  - common/mesh_pkg.sv
  - design/router/router_in_buf.sv
  - design/router/router_out_arb.sv
  - design/router/mesh_router.sv
  - design/nic/mesh_nic.sv
  - design/mesh_top.sv
  - target: test
    files:
      - tb/mesh_tb.sv

// ==== tb/mesh_tb.sv ====
// mesh testbench with register port driver, per-pair scoreboard and traffic tests
module mesh_tb;
    import mesh_pkg::*;

    localparam int COLS   = 4;
    localparam int ROWS   = 4;
    localparam int N      = COLS * ROWS;
    localparam int TARGET = 2 * COLS + 2;  // node (2,2)

    logic              clk = 1'b0;
    logic              rst_n;
    logic [N-1:0]      nic_en;
    logic [N-1:0]      nic_wr_en;
    nic_reg_e [N-1:0]  nic_addr;
    flit_t [N-1:0]     nic_d_in;
    flit_t [N-1:0]     nic_d_out;

    bit       op_en   [N];  // next register access per node
    bit       op_wr   [N];
    nic_reg_e op_addr [N];
    flit_t    op_data [N];
    flit_t    rd_data [N];  // read data sampled at the access edge

    flit_t sb_q [N][N][$];  // expected flits, [src][dst]
    flit_t last_sent [N];
    int    to_send [N];
    bit    tx_busy [N];
    int    pending;
    int    err_cnt;
    int    tests_ok;
    int    tests_bad;

    mesh_top #(.MESH_COLS(COLS), .MESH_ROWS(ROWS)) DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .nic_en    (nic_en),
        .nic_wr_en (nic_wr_en),
        .nic_addr  (nic_addr),
        .nic_d_in  (nic_d_in),
        .nic_d_out (nic_d_out)
    );

    always #5 clk = ~clk;

    task automatic check_true(bit ok, string msg);
        assert (ok) else begin
            $display("CHECK FAILED at %0t: %s", $time, msg);
            err_cnt++;
        end
    endtask

    task automatic clear_ops();
        for (int n = 0; n < N; n++) begin
            op_en[n]   = 1'b0;
            op_wr[n]   = 1'b0;
            op_addr[n] = NIC_RX_STATUS;
            op_data[n] = '0;
        end
    endtask

    // one bus cycle, driven on the falling edge and sampled at the rising edge
    task automatic run_cycle();
        @(negedge clk);
        for (int n = 0; n < N; n++) begin
            nic_en[n]    = op_en[n];
            nic_wr_en[n] = op_wr[n];
            nic_addr[n]  = op_addr[n];
            nic_d_in[n]  = op_data[n];
        end
        @(posedge clk);
        for (int n = 0; n < N; n++) begin
            rd_data[n] = nic_d_out[n];
        end
    endtask

    task automatic reg_write(int node, nic_reg_e addr, flit_t data);
        clear_ops();
        op_en[node]   = 1'b1;
        op_wr[node]   = 1'b1;
        op_addr[node] = addr;
        op_data[node] = data;
        run_cycle();
    endtask

    task automatic reg_read(int node, nic_reg_e addr, output flit_t data);
        clear_ops();
        op_en[node]   = 1'b1;
        op_addr[node] = addr;
        run_cycle();
        data = rd_data[node];
    endtask

    function automatic flit_t make_flit(int dest);
        flit_t f;
        f        = {$urandom, $urandom};  // src bits random too, NIC replaces them
        f.dest_x = coord_t'(dest % COLS);
        f.dest_y = coord_t'(dest / COLS);
        return f;
    endfunction

    // model of an accepted write, source taken from the sending node
    task automatic record_sent(int src, int dest, flit_t f);
        flit_t exp;
        exp       = f;
        exp.src_x = coord_t'(src % COLS);
        exp.src_y = coord_t'(src / COLS);
        sb_q[src][dest].push_back(exp);
        last_sent[src] = exp;
        pending++;
    endtask

    task automatic check_rx(int node, flit_t got);
        flit_t exp;
        int    src;
        src = int'(got.src_y) * COLS + int'(got.src_x);
        check_true(int'(got.dest_x) == node % COLS && int'(got.dest_y) == node / COLS,
            $sformatf("node %0d received a flit addressed to (%0d,%0d)", node,
                      got.dest_x, got.dest_y));
        if (sb_q[src][node].size() == 0) begin
            check_true(1'b0, $sformatf("unexpected flit %h at node %0d", got, node));
        end else begin
            exp = sb_q[src][node].pop_front();
            pending--;
            check_true(got == exp, $sformatf("node %0d from node %0d got %h expected %h",
                node, src, got, exp));
        end
    endtask

    // poll TX status, then write where the send buffer is empty
    task automatic send_round(int dest);
        clear_ops();
        for (int n = 0; n < N; n++) begin
            op_en[n]   = to_send[n] > 0;
            op_addr[n] = NIC_TX_STATUS;
        end
        run_cycle();
        for (int n = 0; n < N; n++) begin
            tx_busy[n] = op_en[n] && rd_data[n][0];
        end
        clear_ops();
        for (int n = 0; n < N; n++) begin
            if (to_send[n] > 0 && !tx_busy[n]) begin
                int d;
                d          = (dest < 0) ? int'($urandom_range(N - 1)) : dest;
                op_en[n]   = 1'b1;
                op_wr[n]   = 1'b1;
                op_addr[n] = NIC_TX_DATA;
                op_data[n] = make_flit(d);
                record_sent(n, d, op_data[n]);
                to_send[n]--;
            end
        end
        run_cycle();
    endtask

    task automatic drain_round();
        bit rx_full [N];
        clear_ops();
        for (int n = 0; n < N; n++) begin
            op_en[n]   = 1'b1;
            op_addr[n] = NIC_RX_STATUS;
        end
        run_cycle();
        clear_ops();
        for (int n = 0; n < N; n++) begin
            rx_full[n] = rd_data[n][0];
            op_en[n]   = rx_full[n];
            op_addr[n] = NIC_RX_DATA;
        end
        run_cycle();
        for (int n = 0; n < N; n++) begin
            if (rx_full[n]) begin
                check_rx(n, rd_data[n]);
            end
        end
    endtask

    // dest below zero picks a random destination per flit
    task automatic run_traffic(int dest, int max_rounds, string what);
        int rounds;
        int left;
        rounds = 0;
        do begin
            send_round(dest);
            drain_round();
            left = 0;
            for (int n = 0; n < N; n++) begin
                left += to_send[n];
            end
            rounds++;
        end while ((left > 0 || pending > 0) && rounds < max_rounds);
        if (left > 0 || pending > 0) begin
            $display("timeout waiting for %s, %0d unsent and %0d undelivered flits",
                     what, left, pending);
            err_cnt++;
        end
    endtask

    task automatic end_test(string name, int errs_before);
        if (err_cnt == errs_before) begin
            tests_ok++;
            $display("test %-28s passed", name);
        end else begin
            tests_bad++;
            $display("test %-28s failed, %0d errors", name, err_cnt - errs_before);
        end
    endtask

    initial begin
        int    errs;
        int    stalled;
        int    rounds;
        int    busy_run [N];
        int    senders [8] = '{0, 1, 3, 5, 7, 12, 13, 15};
        flit_t rd;
        flit_t ghost;

        void'($urandom(32'h9273_06df));
        rst_n     = 1'b0;
        nic_en    = '0;
        nic_wr_en = '0;
        nic_d_in  = '0;
        pending   = 0;
        err_cnt   = 0;
        tests_ok  = 0;
        tests_bad = 0;
        for (int n = 0; n < N; n++) begin
            nic_addr[n] = NIC_RX_STATUS;
            to_send[n]  = 0;
            busy_run[n] = 0;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        errs = err_cnt;
        for (int a = 0; a < 2; a++) begin
            clear_ops();
            for (int n = 0; n < N; n++) begin
                op_en[n]   = 1'b1;
                op_addr[n] = (a == 0) ? NIC_RX_STATUS : NIC_TX_STATUS;
            end
            run_cycle();
            for (int n = 0; n < N; n++) begin
                check_true(rd_data[n] == '0, $sformatf("node %0d status %s reads %h after reset",
                    n, op_addr[n].name(), rd_data[n]));
            end
        end
        end_test("reset state", errs);

        errs = err_cnt;
        for (int d = 0; d < N; d++) begin
            to_send[0] = 1;
            run_traffic(d, 100, $sformatf("single flit from node 0 to node %0d", d));
        end
        end_test("single delivery", errs);

        errs = err_cnt;
        for (int n = 0; n < N; n++) begin
            to_send[n] = 20;
        end
        run_traffic(-1, 3000, "random traffic to drain");
        end_test("random traffic", errs);

        // node (2,2) is not drained, so the routes toward it fill up
        errs    = err_cnt;
        stalled = -1;
        rounds  = 0;
        foreach (senders[i]) begin
            to_send[senders[i]] = 8;
        end
        while (stalled < 0 && rounds < 400) begin
            send_round(TARGET);
            foreach (senders[i]) begin
                busy_run[senders[i]] = tx_busy[senders[i]] ? busy_run[senders[i]] + 1 : 0;
                if (busy_run[senders[i]] >= 16 && stalled < 0) begin
                    stalled = senders[i];
                end
            end
            rounds++;
        end
        if (stalled < 0) begin
            $display("timeout waiting for a sender to stall behind node (2,2)");
            err_cnt++;
        end
        end_test("back-pressure stall", errs);

        errs = err_cnt;
        if (stalled >= 0) begin
            reg_read(stalled, NIC_TX_STATUS, rd);
            check_true(rd == flit_t'(1), $sformatf("node %0d send buffer not full", stalled));
            ghost         = make_flit(TARGET);
            ghost.payload = ~last_sent[stalled].payload;  // must never show up
            reg_write(stalled, NIC_TX_DATA, ghost);
            reg_read(stalled, NIC_TX_DATA, rd);
            check_true(rd == last_sent[stalled], $sformatf(
                "node %0d send buffer holds %h after write to full buffer", stalled, rd));
        end
        for (int n = 0; n < N; n++) begin
            to_send[n] = 0;
        end
        run_traffic(-1, 2000, "back-pressure flits to drain");
        end_test("full send buffer and drain", errs);

        $display("tests: %0d passed, %0d failed, %0d check errors",
                 tests_ok, tests_bad, err_cnt);
        if (err_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== design/mesh_top.sv ====
// mesh of NIC and router nodes with neighbour links and edge tie-offs
module mesh_top #(
    parameter int MESH_COLS = 4,
    parameter int MESH_ROWS = 4
) (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic               [MESH_COLS*MESH_ROWS-1:0]  nic_en,
    input  logic               [MESH_COLS*MESH_ROWS-1:0]  nic_wr_en,
    input  mesh_pkg::nic_reg_e [MESH_COLS*MESH_ROWS-1:0]  nic_addr,
    input  mesh_pkg::flit_t    [MESH_COLS*MESH_ROWS-1:0]  nic_d_in,
    output mesh_pkg::flit_t    [MESH_COLS*MESH_ROWS-1:0]  nic_d_out
);
    import mesh_pkg::*;

    localparam int N_NODES = MESH_COLS * MESH_ROWS;

    // router side of every link, indexed [node][port]
    logic  [NUM_PORTS-1:0] rt_in_valid  [N_NODES];
    logic  [NUM_PORTS-1:0] rt_in_ready  [N_NODES];
    flit_t [NUM_PORTS-1:0] rt_in_flit   [N_NODES];
    logic  [NUM_PORTS-1:0] rt_out_valid [N_NODES];
    logic  [NUM_PORTS-1:0] rt_out_ready [N_NODES];
    flit_t [NUM_PORTS-1:0] rt_out_flit  [N_NODES];

    for (genvar y = 0; y < MESH_ROWS; y++) begin : g_row
        for (genvar x = 0; x < MESH_COLS; x++) begin : g_col
            localparam int NODE = y * MESH_COLS + x;

            mesh_nic #(.X_POS(x), .Y_POS(y)) u_nic (
                .clk           (clk),
                .rst_n         (rst_n),
                .nic_en        (nic_en[NODE]),
                .nic_wr_en     (nic_wr_en[NODE]),
                .nic_addr      (nic_addr[NODE]),
                .nic_d_in      (nic_d_in[NODE]),
                .nic_d_out     (nic_d_out[NODE]),
                .net_out_valid (rt_in_valid[NODE][PORT_LOCAL]),
                .net_out_ready (rt_in_ready[NODE][PORT_LOCAL]),
                .net_out_flit  (rt_in_flit[NODE][PORT_LOCAL]),
                .net_in_valid  (rt_out_valid[NODE][PORT_LOCAL]),
                .net_in_ready  (rt_out_ready[NODE][PORT_LOCAL]),
                .net_in_flit   (rt_out_flit[NODE][PORT_LOCAL])
            );

            mesh_router #(
                .X_POS (x), .Y_POS (y), .MESH_COLS (MESH_COLS), .MESH_ROWS (MESH_ROWS)
            ) u_router (
                .clk       (clk),
                .rst_n     (rst_n),
                .in_valid  (rt_in_valid[NODE]),
                .in_ready  (rt_in_ready[NODE]),
                .in_flit   (rt_in_flit[NODE]),
                .out_valid (rt_out_valid[NODE]),
                .out_ready (rt_out_ready[NODE]),
                .out_flit  (rt_out_flit[NODE])
            );

            if (x < MESH_COLS - 1) begin : g_east
                assign rt_in_valid[NODE][PORT_EAST]  = rt_out_valid[NODE+1][PORT_WEST];
                assign rt_in_flit[NODE][PORT_EAST]   = rt_out_flit[NODE+1][PORT_WEST];
                assign rt_out_ready[NODE][PORT_EAST] = rt_in_ready[NODE+1][PORT_WEST];
            end else begin : g_east_edge
                assign rt_in_valid[NODE][PORT_EAST]  = 1'b0;
                assign rt_in_flit[NODE][PORT_EAST]   = '0;
                assign rt_out_ready[NODE][PORT_EAST] = 1'b0;
            end

            if (x > 0) begin : g_west
                assign rt_in_valid[NODE][PORT_WEST]  = rt_out_valid[NODE-1][PORT_EAST];
                assign rt_in_flit[NODE][PORT_WEST]   = rt_out_flit[NODE-1][PORT_EAST];
                assign rt_out_ready[NODE][PORT_WEST] = rt_in_ready[NODE-1][PORT_EAST];
            end else begin : g_west_edge
                assign rt_in_valid[NODE][PORT_WEST]  = 1'b0;
                assign rt_in_flit[NODE][PORT_WEST]   = '0;
                assign rt_out_ready[NODE][PORT_WEST] = 1'b0;
            end

            if (y < MESH_ROWS - 1) begin : g_north
                assign rt_in_valid[NODE][PORT_NORTH]  = rt_out_valid[NODE+MESH_COLS][PORT_SOUTH];
                assign rt_in_flit[NODE][PORT_NORTH]   = rt_out_flit[NODE+MESH_COLS][PORT_SOUTH];
                assign rt_out_ready[NODE][PORT_NORTH] = rt_in_ready[NODE+MESH_COLS][PORT_SOUTH];
            end else begin : g_north_edge
                assign rt_in_valid[NODE][PORT_NORTH]  = 1'b0;
                assign rt_in_flit[NODE][PORT_NORTH]   = '0;
                assign rt_out_ready[NODE][PORT_NORTH] = 1'b0;
            end

            if (y > 0) begin : g_south
                assign rt_in_valid[NODE][PORT_SOUTH]  = rt_out_valid[NODE-MESH_COLS][PORT_NORTH];
                assign rt_in_flit[NODE][PORT_SOUTH]   = rt_out_flit[NODE-MESH_COLS][PORT_NORTH];
                assign rt_out_ready[NODE][PORT_SOUTH] = rt_in_ready[NODE-MESH_COLS][PORT_NORTH];
            end else begin : g_south_edge
                assign rt_in_valid[NODE][PORT_SOUTH]  = 1'b0;
                assign rt_in_flit[NODE][PORT_SOUTH]   = '0;
                assign rt_out_ready[NODE][PORT_SOUTH] = 1'b0;
            end
        end
    end

endmodule

// ==== design/nic/mesh_nic.sv ====
// network interface with one-flit send and receive buffers behind a register port
module mesh_nic #(
    parameter int X_POS = 0,
    parameter int Y_POS = 0
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               nic_en,
    input  logic               nic_wr_en,
    input  mesh_pkg::nic_reg_e nic_addr,
    input  mesh_pkg::flit_t    nic_d_in,
    output mesh_pkg::flit_t    nic_d_out,
    output logic               net_out_valid,
    input  logic               net_out_ready,
    output mesh_pkg::flit_t    net_out_flit,
    input  logic               net_in_valid,
    output logic               net_in_ready,
    input  mesh_pkg::flit_t    net_in_flit
);
    import mesh_pkg::*;

    flit_t tx_q;
    flit_t rx_q;
    flit_t tx_load;
    logic  tx_full_q;
    logic  rx_full_q;
    logic  tx_wr;
    logic  rx_rd;

    assign tx_wr = nic_en && nic_wr_en && nic_addr == NIC_TX_DATA && !tx_full_q;  // dropped if full
    assign rx_rd = nic_en && !nic_wr_en && nic_addr == NIC_RX_DATA && rx_full_q;

    // source field always comes from this node
    always_comb begin
        tx_load       = nic_d_in;
        tx_load.src_x = coord_t'(X_POS);
        tx_load.src_y = coord_t'(Y_POS);
    end

    assign net_out_valid = tx_full_q;
    assign net_out_flit  = tx_q;
    assign net_in_ready  = !rx_full_q;  // undrained buffer backs up the mesh

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tx_full_q <= 1'b0;
            rx_full_q <= 1'b0;
        end else begin
            if (tx_wr) begin
                tx_full_q <= 1'b1;
            end else if (net_out_valid && net_out_ready) begin
                tx_full_q <= 1'b0;
            end
            if (net_in_valid && net_in_ready) begin
                rx_full_q <= 1'b1;
            end else if (rx_rd) begin
                rx_full_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tx_wr) begin
            tx_q <= tx_load;
        end
        if (net_in_valid && net_in_ready) begin
            rx_q <= net_in_flit;
        end
    end

    // register read mux
    always_comb begin
        nic_d_out = '0;
        if (nic_en) begin
            case (nic_addr)
                NIC_RX_DATA:   nic_d_out = rx_q;
                NIC_RX_STATUS: nic_d_out = flit_t'({{(FLIT_W-1){1'b0}}, rx_full_q});
                NIC_TX_DATA:   nic_d_out = tx_q;
                NIC_TX_STATUS: nic_d_out = flit_t'({{(FLIT_W-1){1'b0}}, tx_full_q});
                default:       nic_d_out = '0;
            endcase
        end
    end

    a_rx_for_us: assert property (@(posedge clk) disable iff (!rst_n)
        net_in_valid && net_in_ready |-> net_in_flit.dest_x == coord_t'(X_POS)
                                      && net_in_flit.dest_y == coord_t'(Y_POS))
        else $error("NIC (%0d,%0d) received a flit for another node", X_POS, Y_POS);

endmodule

// ==== design/router/mesh_router.sv ====
// five-port XY mesh router with input buffers, output arbiters and crossbar
module mesh_router #(
    parameter int X_POS     = 0,
    parameter int Y_POS     = 0,
    parameter int MESH_COLS = 4,
    parameter int MESH_ROWS = 4
) (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic            [mesh_pkg::NUM_PORTS-1:0] in_valid,
    output logic            [mesh_pkg::NUM_PORTS-1:0] in_ready,
    input  mesh_pkg::flit_t [mesh_pkg::NUM_PORTS-1:0] in_flit,
    output logic            [mesh_pkg::NUM_PORTS-1:0] out_valid,
    input  logic            [mesh_pkg::NUM_PORTS-1:0] out_ready,
    output mesh_pkg::flit_t [mesh_pkg::NUM_PORTS-1:0] out_flit
);
    import mesh_pkg::*;

    logic [NUM_PORTS-1:0] buf_valid;
    flit_t                buf_flit  [NUM_PORTS];
    port_e                buf_port  [NUM_PORTS];
    logic [NUM_PORTS-1:0] buf_taken;
    logic [NUM_PORTS-1:0] req_m     [NUM_PORTS];  // [out][in]
    logic [NUM_PORTS-1:0] grant_m   [NUM_PORTS];  // [out][in]
    logic [NUM_PORTS-1:0] taken_m   [NUM_PORTS];  // [in][out]

    // turns that XY routing can take, no U-turns and no Y to X
    function automatic logic turn_ok(int src, int dst);
        case (src)
            PORT_NORTH: return dst == PORT_SOUTH || dst == PORT_LOCAL;
            PORT_SOUTH: return dst == PORT_NORTH || dst == PORT_LOCAL;
            PORT_EAST:  return dst != PORT_EAST;
            PORT_WEST:  return dst != PORT_WEST;
            default:    return 1'b1;
        endcase
    endfunction

    function automatic logic has_nbr(port_e p);
        case (p)
            PORT_NORTH: return Y_POS < MESH_ROWS - 1;
            PORT_SOUTH: return Y_POS > 0;
            PORT_EAST:  return X_POS < MESH_COLS - 1;
            PORT_WEST:  return X_POS > 0;
            default:    return 1'b1;
        endcase
    endfunction

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_in
        router_in_buf #(
            .X_POS (X_POS),
            .Y_POS (Y_POS)
        ) u_buf (
            .clk       (clk),
            .rst_n     (rst_n),
            .in_valid  (in_valid[i]),
            .in_ready  (in_ready[i]),
            .in_flit   (in_flit[i]),
            .out_valid (buf_valid[i]),
            .out_flit  (buf_flit[i]),
            .out_port  (buf_port[i]),
            .out_taken (buf_taken[i])
        );

        assign buf_taken[i] = |taken_m[i];

        a_no_edge_route: assert property (@(posedge clk) disable iff (!rst_n)
            buf_valid[i] |-> has_nbr(buf_port[i]))
            else $error("flit at (%0d,%0d) routed off the mesh edge", X_POS, Y_POS);

        a_dest_range: assert property (@(posedge clk) disable iff (!rst_n)
            buf_valid[i] |-> int'(buf_flit[i].dest_x) < MESH_COLS
                          && int'(buf_flit[i].dest_y) < MESH_ROWS)
            else $error("flit destination outside the %0dx%0d mesh", MESH_COLS, MESH_ROWS);
    end

    for (genvar o = 0; o < NUM_PORTS; o++) begin : g_out
        // only legal turns are wired, keeps the ready chain acyclic
        for (genvar i = 0; i < NUM_PORTS; i++) begin : g_xbar
            if (turn_ok(i, o)) begin : g_turn
                assign req_m[o][i]   = buf_valid[i] && buf_port[i] == port_e'(o);
                assign taken_m[i][o] = grant_m[o][i] && out_ready[o];
            end else begin : g_no_turn
                assign req_m[o][i]   = 1'b0;
                assign taken_m[i][o] = 1'b0;
            end
        end

        router_out_arb u_arb (
            .clk       (clk),
            .rst_n     (rst_n),
            .req       (req_m[o]),
            .out_ready (out_ready[o]),
            .grant     (grant_m[o]),
            .out_valid (out_valid[o])
        );
    end

    // crossbar
    always_comb begin
        for (int o = 0; o < NUM_PORTS; o++) begin
            out_flit[o] = '0;
            for (int i = 0; i < NUM_PORTS; i++) begin
                if (grant_m[o][i]) begin
                    out_flit[o] = buf_flit[i];
                end
            end
        end
    end

endmodule

// ==== design/router/router_out_arb.sv ====
// round-robin arbiter for one router output, grant locked while stalled
module router_out_arb (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [mesh_pkg::NUM_PORTS-1:0] req,
    input  logic                           out_ready,
    output logic [mesh_pkg::NUM_PORTS-1:0] grant,
    output logic                           out_valid
);
    import mesh_pkg::*;

    localparam int IDX_W = $clog2(NUM_PORTS);

    logic [IDX_W-1:0]     last_q;        // last port that transferred
    logic                 hold_q;        // previous cycle stalled
    logic [NUM_PORTS-1:0] hold_grant_q;
    logic [NUM_PORTS-1:0] rr_grant;
    logic [IDX_W-1:0]     grant_idx;

    // search starts one past the last winner
    always_comb begin
        logic found;
        int   idx;
        found    = 1'b0;
        rr_grant = '0;
        for (int k = 1; k <= NUM_PORTS; k++) begin
            idx = (int'(last_q) + k) % NUM_PORTS;
            if (!found && req[idx]) begin
                rr_grant[idx] = 1'b1;
                found         = 1'b1;
            end
        end
    end

    assign grant     = hold_q ? hold_grant_q : rr_grant;  // stalled requester keeps the port
    assign out_valid = |req;

    always_comb begin
        grant_idx = '0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (grant[i]) begin
                grant_idx = IDX_W'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            last_q       <= IDX_W'(NUM_PORTS - 1);  // local port wins first
            hold_q       <= 1'b0;
            hold_grant_q <= '0;
        end else begin
            hold_q       <= out_valid && !out_ready;
            hold_grant_q <= grant;
            if (out_valid && out_ready) begin
                last_q <= grant_idx;
            end
        end
    end

    a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(grant))
        else $error("output arbiter granted more than one input");

    // held input must still be requesting when its grant is replayed
    a_grant_stable: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> (grant & req) == $past(grant))
        else $error("output arbiter lost its granted request during a stall");

endmodule

// ==== design/router/router_in_buf.sv ====
// one-entry router input buffer with XY output port selection
module router_in_buf #(
    parameter int X_POS = 0,
    parameter int Y_POS = 0
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            in_valid,
    output logic            in_ready,
    input  mesh_pkg::flit_t in_flit,
    output logic            out_valid,
    output mesh_pkg::flit_t out_flit,
    output mesh_pkg::port_e out_port,
    input  logic            out_taken
);
    import mesh_pkg::*;

    logic  full_q;
    flit_t flit_q;

    assign in_ready  = !full_q || out_taken;  // refill in the cycle the flit leaves
    assign out_valid = full_q;
    assign out_flit  = flit_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            full_q <= 1'b0;
        end else if (in_valid && in_ready) begin
            full_q <= 1'b1;
        end else if (out_taken) begin
            full_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            flit_q <= in_flit;
        end
    end

    // X is resolved before Y
    always_comb begin
        if (int'(flit_q.dest_x) > X_POS) begin
            out_port = PORT_EAST;
        end else if (int'(flit_q.dest_x) < X_POS) begin
            out_port = PORT_WEST;
        end else if (int'(flit_q.dest_y) > Y_POS) begin
            out_port = PORT_NORTH;
        end else if (int'(flit_q.dest_y) < Y_POS) begin
            out_port = PORT_SOUTH;
        end else begin
            out_port = PORT_LOCAL;  // arrived
        end
    end

endmodule

// ==== common/mesh_pkg.sv ====
// mesh widths, flit layout, router port and NIC register encodings
package mesh_pkg;

    localparam int FLIT_W    = 64;
    localparam int COORD_W   = 2;
    localparam int RSVD_W    = 8;
    localparam int PAYLOAD_W = FLIT_W - 4 * COORD_W - RSVD_W;  // 48 bits left for data
    localparam int NUM_PORTS = 5;

    typedef logic [COORD_W-1:0] coord_t;

    // single-flit packet, header in the top byte
    typedef struct packed {
        coord_t                 dest_x;
        coord_t                 dest_y;
        coord_t                 src_x;
        coord_t                 src_y;
        logic [RSVD_W-1:0]      rsvd;     // carried through untouched
        logic [PAYLOAD_W-1:0]   payload;
    } flit_t;

    // router port index, north is +y and east is +x
    typedef enum logic [2:0] {
        PORT_LOCAL = 3'd0,
        PORT_NORTH = 3'd1,
        PORT_SOUTH = 3'd2,
        PORT_EAST  = 3'd3,
        PORT_WEST  = 3'd4
    } port_e;

    // processor side register map of the NIC
    typedef enum logic [1:0] {
        NIC_RX_DATA   = 2'd0,
        NIC_RX_STATUS = 2'd1,
        NIC_TX_DATA   = 2'd2,
        NIC_TX_STATUS = 2'd3
    } nic_reg_e;

endpackage
